//--- Bender.yml
package:
  name: mul_div_unit

sources:
  - rtl/md_pkg.sv
  - rtl/md_req_capture.sv
  - rtl/md_booth_mul.sv
  - rtl/md_radix4_div.sv
  - rtl/md_result_fix.sv
  - rtl/mul_div_unit.sv
  - target: test
    files:
      - verif/md_props.sv
      - verif/md_checker.sv
      - verif/md_tb.sv

//--- all.f
rtl/md_pkg.sv
rtl/md_req_capture.sv
rtl/md_booth_mul.sv
rtl/md_radix4_div.sv
rtl/md_result_fix.sv
rtl/mul_div_unit.sv
verif/md_props.sv
verif/md_checker.sv
verif/md_tb.sv

//--- rtl/md_booth_mul.sv
module md_booth_mul import md_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  md_mul_job_t job,
   output logic        done,
   output md_wide_t    result
);

   logic [CNT_W-1:0]     cnt;
   logic [XLEN:0]        mcand;
   logic [XLEN:0]        window;    // multiplier bits with appended zero
   logic [MUL_ACC_W-1:0] acc;
   logic [MUL_ACC_W-1:0] acc_init;
   logic [MUL_ACC_W-1:0] m_ext;
   logic [MUL_ACC_W-1:0] pp_hi;
   logic [MUL_ACC_W-1:0] pp_lo;
   logic [MUL_ACC_W-1:0] acc_sh;
   logic [MUL_ACC_W-1:0] pp_hi_sh;
   logic [MUL_ACC_W-1:0] csa_s;
   logic [MUL_ACC_W-1:0] csa_c;
   logic [MUL_ACC_W-1:0] acc_next;

   function automatic logic [MUL_ACC_W-1:0] booth_pp(input logic [2:0] br,
                                                    input logic [MUL_ACC_W-1:0] m);
      case (br)
         3'b001, 3'b010: booth_pp = m;
         3'b011:         booth_pp = m << 1;
         3'b100:         booth_pp = -(m << 1);
         3'b101, 3'b110: booth_pp = -m;
         default:        booth_pp = '0;
      endcase
   endfunction

   // digits run msb first, the accumulator shifts left 4 per pass
   assign m_ext    = {{(MUL_ACC_W-XLEN-1){mcand[XLEN]}}, mcand};
   assign pp_hi    = booth_pp(window[XLEN:XLEN-2], m_ext);
   assign pp_lo    = booth_pp(window[XLEN-2:XLEN-4], m_ext);
   assign acc_sh   = acc << 4;
   assign pp_hi_sh = pp_hi << 2;

   // 3:2 compressor then a single carry-propagate add
   assign csa_s    = acc_sh ^ pp_hi_sh ^ pp_lo;
   assign csa_c    = ((acc_sh & pp_hi_sh) | (pp_hi_sh & pp_lo) | (acc_sh & pp_lo)) << 1;
   assign acc_next = csa_s + csa_c;

   // extra top digit when the 33-bit multiplier exceeds the 32-bit signed range
   assign acc_init = (job.mplier[XLEN-1] & ~job.mplier[XLEN]) ?
                     {{(MUL_ACC_W-XLEN-1){job.mcand[XLEN]}}, job.mcand} : '0;

   assign done   = (cnt == CNT_W'(1));
   assign result = md_wide_t'(acc_next[2*XLEN-1:0]);

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
      end else if (start) begin
         cnt <= CNT_W'(MUL_ITER);
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         mcand  <= job.mcand;
         window <= {job.mplier[XLEN-1:0], 1'b0};
         acc    <= acc_init;
      end else if (cnt != '0) begin
         window <= window << 4;
         acc    <= acc_next;
      end
   end

endmodule

//--- rtl/md_pkg.sv
package md_pkg;

   localparam int XLEN      = 32;
   localparam int MUL_ACC_W = 66;   // 64-bit product plus two guard bits

   localparam logic OUT_LO = 1'b0;  // product low or quotient
   localparam logic OUT_HI = 1'b1;  // product high or remainder

   localparam int MUL_ITER = 8;     // two booth digits per pass
   localparam int DIV_ITER = 16;    // two quotient bits per pass
   localparam int CNT_W    = 5;

   typedef enum logic {
      MD_OP_MUL = 1'b0,
      MD_OP_DIV = 1'b1
   } md_op_e;

   typedef struct packed {
      md_op_e          op;
      logic            a_signed;
      logic            b_signed;
      logic            out_sel;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
   } md_req_t;

   typedef struct packed {
      logic [XLEN:0] mcand;   // sign extended per operand flag
      logic [XLEN:0] mplier;
      logic          out_sel;
   } md_mul_job_t;

   typedef struct packed {
      logic [XLEN-1:0] dividend;      // magnitude
      logic [XLEN-1:0] divisor;       // magnitude
      logic [XLEN-1:0] raw_dividend;
      logic            neg_quot;
      logic            neg_rem;
      logic            div_zero;
      logic            out_sel;
   } md_div_job_t;

   typedef struct packed {
      logic [XLEN-1:0] hi;
      logic [XLEN-1:0] lo;
   } md_wide_t;

endpackage

//--- rtl/md_radix4_div.sv
module md_radix4_div import md_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  md_div_job_t job,
   output logic        done,
   output md_wide_t    result
);

   logic [CNT_W-1:0] cnt;
   logic             div_zero;
   logic [XLEN-1:0]  divisor;
   logic [XLEN-1:0]  rem;
   logic [XLEN-1:0]  dvd;      // dividend bits still to shift in
   logic [XLEN-1:0]  quot;
   logic [XLEN+2:0]  r4;
   logic [XLEN+2:0]  d1;
   logic [XLEN+2:0]  d2;
   logic [XLEN+2:0]  d3;
   logic [XLEN+2:0]  t1;
   logic [XLEN+2:0]  t2;
   logic [XLEN+2:0]  t3;
   logic [1:0]       dq;
   logic [XLEN-1:0]  sel_rem;
   logic [XLEN-1:0]  quot_next;

   assign r4 = {1'b0, rem, dvd[XLEN-1:XLEN-2]};
   assign d1 = {3'b000, divisor};
   assign d2 = {2'b00, divisor, 1'b0};
   assign d3 = d1 + d2;

   // three trial subtractions in parallel
   assign t1 = r4 - d1;
   assign t2 = r4 - d2;
   assign t3 = r4 - d3;

   always_comb begin
      if (!t3[XLEN+2]) begin
         dq      = 2'd3;
         sel_rem = t3[XLEN-1:0];
      end else if (!t2[XLEN+2]) begin
         dq      = 2'd2;
         sel_rem = t2[XLEN-1:0];
      end else if (!t1[XLEN+2]) begin
         dq      = 2'd1;
         sel_rem = t1[XLEN-1:0];
      end else begin
         dq      = 2'd0;
         sel_rem = r4[XLEN-1:0];
      end
   end

   assign quot_next = {quot[XLEN-3:0], dq};
   assign done      = (cnt == CNT_W'(1));
   assign result    = div_zero ? md_wide_t'({dvd, {XLEN{1'b1}}}) :
                                 md_wide_t'({sel_rem, quot_next});

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
      end else if (start) begin
         cnt <= job.div_zero ? CNT_W'(1) : CNT_W'(DIV_ITER);   // early out
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         div_zero <= job.div_zero;
         divisor  <= job.divisor;
         rem      <= '0;
         dvd      <= job.div_zero ? job.raw_dividend : job.dividend;
      end else if (cnt != '0) begin
         rem  <= sel_rem;
         dvd  <= dvd << 2;
         quot <= quot_next;
      end
   end

endmodule

//--- rtl/md_req_capture.sv
module md_req_capture import md_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        req_valid,
   input  md_req_t     req,
   output logic        req_ready,
   input  logic        mul_done,
   input  logic        div_done,
   output logic        mul_start,
   output md_mul_job_t mul_job,
   output logic        div_start,
   output md_div_job_t div_job
);

   logic        busy;
   logic        accept;
   logic        a_neg;
   logic        b_neg;
   logic        b_zero;
   md_mul_job_t mul_next;
   md_div_job_t div_next;

   assign req_ready = ~busy;
   assign accept    = req_valid & req_ready;

   always_comb begin
      mul_next.mcand   = {req.a_signed & req.a[XLEN-1], req.a};
      mul_next.mplier  = {req.b_signed & req.b[XLEN-1], req.b};
      mul_next.out_sel = req.out_sel;

      // division signedness follows a_signed only
      a_neg  = req.a_signed & req.a[XLEN-1];
      b_neg  = req.a_signed & req.b[XLEN-1];
      b_zero = (req.b == '0);

      div_next.dividend     = a_neg ? -req.a : req.a;
      div_next.divisor      = b_neg ? -req.b : req.b;
      div_next.raw_dividend = req.a;
      div_next.neg_quot     = (a_neg ^ b_neg) & ~b_zero;
      div_next.neg_rem      = a_neg & ~b_zero;
      div_next.div_zero     = b_zero;
      div_next.out_sel      = req.out_sel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         mul_start <= 1'b0;
         div_start <= 1'b0;
      end else begin
         mul_start <= accept & (req.op == MD_OP_MUL);
         div_start <= accept & (req.op == MD_OP_DIV);
         if (accept) begin
            busy <= 1'b1;
         end else if (mul_done | div_done) begin
            busy <= 1'b0;   // ready again next cycle
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && req.op == MD_OP_MUL) begin
         mul_job <= mul_next;
      end
      if (accept && req.op == MD_OP_DIV) begin
         div_job <= div_next;   // held for the result stage
      end
   end

endmodule

//--- rtl/md_result_fix.sv
module md_result_fix import md_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            mul_done,
   input  md_wide_t        mul_result,
   input  logic            mul_out_sel,
   input  logic            div_done,
   input  md_wide_t        div_result,
   input  md_div_job_t     div_job,
   output logic            resp_valid,
   output logic [XLEN-1:0] resp_result
);

   logic [XLEN-1:0] quot_fix;
   logic [XLEN-1:0] rem_fix;
   logic [XLEN-1:0] div_word;
   logic [XLEN-1:0] mul_word;

   // engine works on magnitudes, restore signs here
   assign quot_fix = div_job.neg_quot ? -div_result.lo : div_result.lo;
   assign rem_fix  = div_job.neg_rem ? -div_result.hi : div_result.hi;
   assign div_word = (div_job.out_sel == OUT_HI) ? rem_fix : quot_fix;
   assign mul_word = (mul_out_sel == OUT_HI) ? mul_result.hi : mul_result.lo;

   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= mul_done | div_done;   // single cycle pulse
      end
   end

   always_ff @(posedge clk) begin
      if (mul_done) begin
         resp_result <= mul_word;
      end else if (div_done) begin
         resp_result <= div_word;
      end
   end

endmodule

//--- rtl/mul_div_unit.sv
module mul_div_unit import md_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   input  md_req_t         req,
   output logic            req_ready,
   output logic            resp_valid,
   output logic [XLEN-1:0] resp_result
);

   logic        mul_start;
   logic        mul_done;
   md_mul_job_t mul_job;
   md_wide_t    mul_result;
   logic        div_start;
   logic        div_done;
   md_div_job_t div_job;
   md_wide_t    div_result;

   md_req_capture i_md_req_capture (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .mul_done  (mul_done),
      .div_done  (div_done),
      .mul_start (mul_start),
      .mul_job   (mul_job),
      .div_start (div_start),
      .div_job   (div_job)
   );

   md_booth_mul i_md_booth_mul (
      .clk    (clk),
      .reset  (reset),
      .start  (mul_start),
      .job    (mul_job),
      .done   (mul_done),
      .result (mul_result)
   );

   md_radix4_div i_md_radix4_div (
      .clk    (clk),
      .reset  (reset),
      .start  (div_start),
      .job    (div_job),
      .done   (div_done),
      .result (div_result)
   );

   md_result_fix i_md_result_fix (
      .clk         (clk),
      .reset       (reset),
      .mul_done    (mul_done),
      .mul_result  (mul_result),
      .mul_out_sel (mul_job.out_sel),
      .div_done    (div_done),
      .div_result  (div_result),
      .div_job     (div_job),
      .resp_valid  (resp_valid),
      .resp_result (resp_result)
   );

endmodule

//--- verif/md_checker.sv
module md_checker import md_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   input  logic            req_ready,
   input  md_req_t         req,
   input  logic            resp_valid,
   input  logic [XLEN-1:0] resp_result,
   output int              n_pass,
   output int              n_fail,
   output int              pending
);

   md_req_t sent_q[$];   // accepted, not yet answered
   int      test_no;

   function automatic logic [XLEN-1:0] model_result(input md_req_t r);
      logic signed [63:0] sa;
      logic signed [63:0] sb;
      logic signed [63:0] prod;
      logic signed [63:0] q;
      logic signed [63:0] m;
      sa = r.a_signed ? {{32{r.a[31]}}, r.a} : {32'b0, r.a};
      if (r.op == MD_OP_MUL) begin
         sb   = r.b_signed ? {{32{r.b[31]}}, r.b} : {32'b0, r.b};
         prod = sa * sb;
         return (r.out_sel == OUT_HI) ? prod[63:32] : prod[31:0];
      end
      sb = r.a_signed ? {{32{r.b[31]}}, r.b} : {32'b0, r.b};   // divide uses a_signed
      if (sb == 0) begin
         return (r.out_sel == OUT_HI) ? r.a : '1;
      end
      q = sa / sb;   // truncates toward zero
      m = sa % sb;   // sign of the dividend
      return (r.out_sel == OUT_HI) ? m[31:0] : q[31:0];
   endfunction

   function automatic string describe(input md_req_t r);
      return $sformatf("%s %s as=%0d bs=%0d a=%h b=%h", (r.op == MD_OP_MUL) ? "mul" : "div",
                       (r.out_sel == OUT_HI) ? "hi" : "lo", r.a_signed, r.b_signed, r.a, r.b);
   endfunction

   initial begin
      n_pass  = 0;
      n_fail  = 0;
      pending = 0;
      test_no = 0;
   end

   always @(posedge clk) begin : compare
      md_req_t         r;
      logic [XLEN-1:0] expected;
      if (reset) begin
         sent_q.delete();
      end else begin
         if (resp_valid && sent_q.size() == 0) begin
            $display("response at %0t arrived with no request outstanding", $time);
            n_fail++;
         end else if (resp_valid) begin
            r        = sent_q.pop_front();
            expected = model_result(r);
            test_no++;
            if (resp_result === expected) begin
               $display("test %0d %s -> %h ok", test_no, describe(r), resp_result);
               n_pass++;
            end else begin
               $display("FAIL at %0t: test %0d %s expected %h got %h", $time, test_no,
                        describe(r), expected, resp_result);
               n_fail++;
            end
         end
         if (req_valid && req_ready) begin
            sent_q.push_back(req);
         end
      end
      pending = sent_q.size();
   end

endmodule

//--- verif/md_props.sv
module md_props (
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic req_ready,
   input logic resp_valid
);

   int n_errs = 0;   // failed assertion count

   ready_after_reset: assert property (@(posedge clk) reset |=> req_ready)
      else begin
         $error("req_ready low coming out of reset");
         n_errs++;
      end

   resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
      resp_valid |=> !resp_valid)
      else begin
         $error("resp_valid high for two cycles in a row");
         n_errs++;
      end

   busy_after_accept: assert property (@(posedge clk) disable iff (reset)
      req_valid && req_ready |=> !req_ready)
      else begin
         $error("req_ready still high after a request was taken");
         n_errs++;
      end

   // ready comes back only together with the response
   ready_with_resp: assert property (@(posedge clk) disable iff (reset)
      !req_ready |=> (req_ready == resp_valid))
      else begin
         $error("req_ready and resp_valid out of step");
         n_errs++;
      end

endmodule

bind mul_div_unit md_props i_md_props (.*);

//--- verif/md_tb.sv
module md_tb import md_pkg::*; ();

   localparam int TIMEOUT = 100;   // cycles per wait

   logic            clk;
   logic            reset;
   logic            req_valid;
   md_req_t         req;
   logic            req_ready;
   logic            resp_valid;
   logic [XLEN-1:0] resp_result;
   logic [31:0]     rnd;
   logic            timed_out;
   int              tb_errs;
   int              n_pass;
   int              n_fail;
   int              pending;

   mul_div_unit i_mul_div_unit (.*);

   md_checker i_md_checker (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function logic [31:0] next_rand();
      rnd = xorshift(rnd);
      return rnd;
   endfunction

   function logic [31:0] random_operand();
      case (next_rand() & 32'hf)   // corner values now and then
         32'd0:   return '0;
         32'd1:   return 32'h8000_0000;
         32'd2:   return '1;
         default: return next_rand();
      endcase
   endfunction

   task automatic wait_ready();
      int n;
      n = 0;
      while (!timed_out && req_ready !== 1'b1 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!timed_out && req_ready !== 1'b1) begin
         $display("timeout: req_ready stayed low for %0d cycles", TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_response();
      int n;
      n = 0;
      while (!timed_out && resp_valid !== 1'b1 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!timed_out && resp_valid !== 1'b1) begin
         $display("timeout: no response within %0d cycles", TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   // flags are {out_sel, b_signed, a_signed}
   task automatic issue(input md_op_e op, input logic [2:0] flags, input logic [31:0] a, b);
      wait_ready();
      if (!timed_out) begin
         req_valid = 1'b1;
         req       = '{op, flags[0], flags[1], flags[2], a, b};
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] b;
      int          prop_errs;
      clk       = 1'b0;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      rnd       = 32'hd1cf_2206;
      timed_out = 1'b0;
      tb_errs   = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (req_ready !== 1'b1) begin
         $display("FAIL at %0t: req_ready low after reset", $time);
         tb_errs++;
      end
      repeat (64) begin   // all four sign mixes, both words
         r = next_rand();
         issue(MD_OP_MUL, r[2:0], random_operand(), random_operand());
         wait_response();
      end
      repeat (64) begin
         r = next_rand();
         b = random_operand() >> r[7:3];   // spread divisor sizes
         issue(MD_OP_DIV, {r[2], r[0], r[0]}, random_operand(), (b == '0) ? 32'd7 : b);
         wait_response();
      end
      repeat (8) begin
         r = next_rand();
         issue(MD_OP_DIV, {r[2], r[0], r[0]}, random_operand(), '0);
         wait_response();
      end
      issue(MD_OP_DIV, 3'b011, 32'h8000_0000, '1);   // signed overflow case
      wait_response();
      issue(MD_OP_DIV, 3'b111, 32'h8000_0000, '1);
      wait_response();
      repeat (16) begin   // next request lands in the resp_valid cycle
         r = next_rand();
         issue(r[3] ? MD_OP_DIV : MD_OP_MUL, r[2:0], random_operand(), random_operand() | 32'd1);
      end
      wait_response();
      @(negedge clk);
      if (pending != 0) begin
         $display("%0d requests never got a response", pending);
         tb_errs++;
      end
      prop_errs = i_mul_div_unit.i_md_props.n_errs;
      if (prop_errs != 0) begin
         $display("%0d assertion failures in the handshake properties", prop_errs);
      end
      $display("tests passed %0d, failed %0d, other errors %0d", n_pass, n_fail,
               tb_errs + int'(timed_out) + prop_errs);
      if (n_fail == 0 && tb_errs == 0 && !timed_out && prop_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
